/* rtl/spi_bridge_pkg.sv */
/* SPI bridge shared types and constants.
   Frame, status and AXI4-Lite channel structs. */
`default_nettype none

package spi_bridge_pkg;

  localparam int WORD_BITS = 16;
  localparam int NUM_REGS  = 8;
  localparam int DATA_BITS = 24;

  localparam logic [DATA_BITS-1:0] ID_VALUE = 24'h5A1C0D; // Read-only register 0.

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [WORD_BITS-1:0] word_t;

  typedef struct packed {
    logic       write;
    logic [2:0] reserved; // Ignored.
    logic [3:0] index;
  } opcode_t;

  typedef struct packed {
    logic       read_valid; // Data bytes hold read data.
    logic       overrun;    // A frame was dropped while busy.
    logic [4:0] reserved;
    logic       error;      // Last response was SLVERR.
  } status_t;

  typedef struct packed {
    opcode_t              opcode;
    logic [DATA_BITS-1:0] data;
  } spi_frame_t;

  typedef struct packed {
    status_t              status;
    logic [DATA_BITS-1:0] data;
  } reply_t;

  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* rtl/spi_word_shifter.sv */
/* SPI mode 0 word shifter.
   Oversamples the pins and moves 16-bit words in on MOSI and out on MISO. */
`timescale 1ns/1ps
`default_nettype none

module spi_word_shifter
  import spi_bridge_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         spi_sck,
  input  wire         spi_ss_n,
  input  wire         spi_mosi,
  output logic        spi_miso,
  input  wire word_t  tx_word,
  output word_t       rx_word,
  output logic        rx_valid,
  output logic        frame_start,
  output logic        frame_abort
);

  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_active;
  logic [4:0] bit_cnt;
  word_t      rx_shift;
  word_t      tx_shift;

  // Two sync stages, third stage for edge detect.
  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q  <= 3'b000;
      ss_q   <= 3'b111;
      mosi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck};
      ss_q   <= {ss_q[1:0], spi_ss_n};
      mosi_q <= {mosi_q[0], spi_mosi};
    end
  end

  assign sck_rise    = sck_q[1] & ~sck_q[2];
  assign sck_fall    = ~sck_q[1] & sck_q[2];
  assign ss_active   = ~ss_q[1];
  assign frame_start = ~ss_q[1] & ss_q[2];
  assign frame_abort = ss_q[1] & ~ss_q[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      tx_shift <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!ss_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        if (bit_cnt == 5'(WORD_BITS - 1)) begin
          bit_cnt  <= '0;
          rx_valid <= 1'b1; // Word complete.
        end else begin
          bit_cnt <= bit_cnt + 5'd1;
        end
      end
      if (frame_start) begin
        tx_shift <= tx_word;
      end else if (ss_active && sck_fall) begin
        // Counter back at zero means a word boundary.
        tx_shift <= (bit_cnt == '0) ? tx_word : {tx_shift[WORD_BITS-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ss_active && sck_rise) begin
      rx_shift <= {rx_shift[WORD_BITS-2:0], mosi_q[1]};
      if (bit_cnt == 5'(WORD_BITS - 1)) begin
        rx_word <= {rx_shift[WORD_BITS-2:0], mosi_q[1]};
      end
    end
  end

  assign spi_miso = tx_shift[WORD_BITS-1]; // MSB first.

endmodule

`default_nettype wire

/* rtl/spi_frame_assembler.sv */
/* Frame assembler.
   Joins two received words into a frame and splits the reply into two words. */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_assembler
  import spi_bridge_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire word_t  rx_word,
  input  wire         rx_valid,
  input  wire         frame_start,
  input  wire         frame_abort,
  output word_t       tx_word,
  output spi_frame_t  frame,
  output logic        frame_valid,
  input  wire reply_t reply
);

  logic   word_idx; // 0 = upper half, 1 = lower half.
  word_t  hi_word;
  reply_t reply_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      word_idx    <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      if (frame_abort) begin
        word_idx <= 1'b0; // Drop partial words.
      end else if (rx_valid) begin
        if (!word_idx) begin
          word_idx <= 1'b1;
        end else begin
          word_idx    <= 1'b0;
          frame_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      reply_q <= reply;
    end
    if (rx_valid) begin
      if (!word_idx) begin
        hi_word <= rx_word;
      end else begin
        frame <= {hi_word, rx_word};
      end
    end
  end

  // Bypass at frame start so the shifter loads the fresh reply.
  always_comb begin
    if (frame_start) begin
      tx_word = reply[2*WORD_BITS-1:WORD_BITS];
    end else if (word_idx) begin
      tx_word = reply_q[WORD_BITS-1:0];
    end else begin
      tx_word = reply_q[2*WORD_BITS-1:WORD_BITS];
    end
  end

endmodule

`default_nettype wire

/* rtl/spi_axil_master.sv */
/* Frame decoder and AXI4-Lite master.
   Runs one register access per frame and builds the status reply. */
`timescale 1ns/1ps
`default_nettype none

module spi_axil_master
  import spi_bridge_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire spi_frame_t frame,
  input  wire             frame_valid,
  output reply_t          reply,
  output axil_req_t       axil_req,
  input  wire axil_rsp_t  axil_rsp
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_RESP
  } state_t;

  state_t     state;
  logic       is_read;
  logic       overrun_pend;
  logic       resp_done;
  logic [1:0] resp_code;
  logic [7:0] byte_addr;

  assign byte_addr = {2'b00, frame.opcode.index, 2'b00}; // Index times 4.
  assign resp_done = (axil_req.bready && axil_rsp.bvalid) ||
                     (axil_req.rready && axil_rsp.rvalid);
  assign resp_code = is_read ? axil_rsp.rresp : axil_rsp.bresp;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= S_IDLE;
      is_read      <= 1'b0;
      overrun_pend <= 1'b0;
      axil_req     <= '0;
      reply        <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (frame_valid) begin
            is_read         <= !frame.opcode.write;
            axil_req.awaddr <= byte_addr;
            axil_req.araddr <= byte_addr;
            axil_req.wdata  <= {8'h00, frame.data};
            axil_req.wstrb  <= 4'b0111;
            if (frame.opcode.write) begin
              axil_req.awvalid <= 1'b1;
              axil_req.wvalid  <= 1'b1;
              state            <= S_WRITE;
            end else begin
              axil_req.arvalid <= 1'b1;
              state            <= S_READ;
            end
          end
        end
        S_WRITE: begin
          if (axil_req.awvalid && axil_rsp.awready) axil_req.awvalid <= 1'b0;
          if (axil_req.wvalid && axil_rsp.wready) axil_req.wvalid <= 1'b0;
          // Both channels done, now or earlier.
          if ((!axil_req.awvalid || axil_rsp.awready) &&
              (!axil_req.wvalid || axil_rsp.wready)) begin
            axil_req.bready <= 1'b1;
            state           <= S_RESP;
          end
        end
        S_READ: begin
          if (axil_rsp.arready) begin
            axil_req.arvalid <= 1'b0;
            axil_req.rready  <= 1'b1;
            state            <= S_RESP;
          end
        end
        default: begin
          if (resp_done) begin
            axil_req.bready <= 1'b0;
            axil_req.rready <= 1'b0;
            state           <= S_IDLE;
          end
        end
      endcase

      if (resp_done) begin
        reply.status.read_valid <= is_read;
        reply.status.overrun    <= overrun_pend | frame_valid; // Drop this cycle counts too.
        reply.status.reserved   <= '0;
        reply.status.error      <= (resp_code == RESP_SLVERR);
        reply.data              <= is_read ? axil_rsp.rdata[DATA_BITS-1:0] : '0;
        overrun_pend            <= 1'b0;
      end else if (frame_valid && state != S_IDLE) begin
        overrun_pend <= 1'b1; // Busy, frame dropped.
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/axil_reg_bank.sv */
/* AXI4-Lite register bank.
   Read-only ID at index 0, seven writable 24-bit registers above it. */
`timescale 1ns/1ps
`default_nettype none

module axil_reg_bank
  import spi_bridge_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire axil_req_t axil_req,
  output axil_rsp_t      axil_rsp
);

  logic [DATA_BITS-1:0] regs [1:NUM_REGS-1];
  logic [5:0]           wr_idx;
  logic [5:0]           rd_idx;
  logic                 wr_go;
  logic                 rd_go;
  logic                 wr_err;
  logic                 rd_err;
  logic                 bvalid_q;
  logic                 rvalid_q;
  logic [1:0]           bresp_q;
  logic [1:0]           rresp_q;
  logic [31:0]          rdata_q;

  assign wr_idx = axil_req.awaddr[7:2];
  assign rd_idx = axil_req.araddr[7:2];
  assign wr_go  = axil_req.awvalid && axil_req.wvalid && !bvalid_q; // Both beats together.
  assign rd_go  = axil_req.arvalid && !rvalid_q;
  assign wr_err = (wr_idx == '0) || (wr_idx >= NUM_REGS); // ID is read-only.
  assign rd_err = (rd_idx >= NUM_REGS);

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_go) begin
        bvalid_q <= 1'b1;
        if (!wr_err) begin
          for (int b = 0; b < DATA_BITS / 8; b++) begin
            if (axil_req.wstrb[b]) begin
              regs[wr_idx[2:0]][8*b +: 8] <= axil_req.wdata[8*b +: 8];
            end
          end
        end
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_go) begin
      rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
      if (rd_err) begin
        rdata_q <= '0; // Error reads return zero.
      end else if (rd_idx == '0) begin
        rdata_q <= {8'h00, ID_VALUE};
      end else begin
        rdata_q <= {8'h00, regs[rd_idx[2:0]]};
      end
    end
  end

  always_comb begin
    axil_rsp.awready = wr_go;
    axil_rsp.wready  = wr_go;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_go;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

`default_nettype wire

/* rtl/spi_axil_bridge_top.sv */
/* SPI to register bridge top level.
   SPI slave front end driving an internal AXI4-Lite register bank. */
`timescale 1ns/1ps
`default_nettype none

module spi_axil_bridge_top
  import spi_bridge_pkg::*;
(
  input  wire  clk,
  input  wire  reset,
  input  wire  spi_sck,
  input  wire  spi_ss_n,
  input  wire  spi_mosi,
  output logic spi_miso
);

  word_t      tx_word;
  word_t      rx_word;
  logic       rx_valid;
  logic       frame_start;
  logic       frame_abort;
  spi_frame_t frame;
  logic       frame_valid;
  reply_t     reply;
  axil_req_t  axil_req;
  axil_rsp_t  axil_rsp;

  spi_word_shifter u_shifter (
    .clk         (clk),
    .reset       (reset),
    .spi_sck     (spi_sck),
    .spi_ss_n    (spi_ss_n),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .tx_word     (tx_word),
    .rx_word     (rx_word),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .frame_abort (frame_abort)
  );

  spi_frame_assembler u_assembler (
    .clk         (clk),
    .reset       (reset),
    .rx_word     (rx_word),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .frame_abort (frame_abort),
    .tx_word     (tx_word),
    .frame       (frame),
    .frame_valid (frame_valid),
    .reply       (reply)
  );

  spi_axil_master u_master (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .reply       (reply),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp)
  );

  axil_reg_bank u_bank (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

endmodule

`default_nettype wire

/* verification/bridge_checker.sv */
/* Bridge checker.
   Rebuilds SPI frames from the pins and compares each reply with a reference model. */
`timescale 1ns/1ps
`default_nettype none

module bridge_checker
  import spi_bridge_pkg::*;
(
  input  wire spi_sck,
  input  wire spi_ss_n,
  input  wire spi_mosi,
  input  wire spi_miso,
  output int  errors,
  output int  frames_checked,
  output int  partial_frames
);

  logic [DATA_BITS-1:0] model_regs [0:NUM_REGS-1];
  reply_t               expected;
  logic [31:0]          mosi_bits;
  logic [31:0]          miso_bits;
  int                   bit_cnt;

  initial begin
    expected  = '0; // Nothing ran before the first frame.
    mosi_bits = '0;
    miso_bits = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
  end

  // Reply that the bridge owes after running one command.
  // The SS gap always covers the command latency, so overrun stays clear.
  function automatic reply_t predict_reply(input spi_frame_t cmd);
    reply_t     r;
    logic [3:0] idx;
    r   = '0;
    idx = cmd.opcode.index;
    if (cmd.opcode.write) begin
      r.status.error = (idx == 4'd0) || (idx >= 4'(NUM_REGS)); // ID is read-only.
      if (!r.status.error) begin
        model_regs[idx[2:0]] = cmd.data;
      end
    end else begin
      r.status.read_valid = 1'b1;
      if (idx >= 4'(NUM_REGS)) begin
        r.status.error = 1'b1; // Data stays zero.
      end else if (idx == 4'd0) begin
        r.data = ID_VALUE;
      end else begin
        r.data = model_regs[idx[2:0]];
      end
    end
    return r;
  endfunction

  task automatic check_frame();
    spi_frame_t cmd;
    reply_t     got;
    cmd = mosi_bits;
    got = miso_bits;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: frame %0d reply %h, expected %h (command %h)",
               $time, frames_checked, got, expected, cmd);
    end
    frames_checked++;
    expected = predict_reply(cmd);
  endtask

  // SS going high closes a frame; only full frames count as commands.
  always @(posedge spi_sck or posedge spi_ss_n) begin
    if (spi_ss_n) begin
      if (bit_cnt == 2 * WORD_BITS) begin
        check_frame();
      end else if (bit_cnt != 0) begin
        partial_frames++;
      end
      bit_cnt = 0;
    end else begin
      mosi_bits = {mosi_bits[30:0], spi_mosi};
      miso_bits = {miso_bits[30:0], spi_miso};
      bit_cnt++;
    end
  end

endmodule

`default_nettype wire

/* verification/tb_spi_axil_bridge.sv */
/* Testbench for the SPI to register bridge.
   Acts as a mode 0 SPI master; replies are checked in bridge_checker. */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_axil_bridge
  import spi_bridge_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int SCK_HALF   = 4; // Clocks per SCK phase.
  localparam int SS_GAP     = 8;
  localparam int FRAME_CLKS = 2 * SCK_HALF * (2 * WORD_BITS + 1) + SS_GAP + 1;
  localparam int MAX_FRAMES = 64;
  localparam int TIMEOUT_NS = (MAX_FRAMES * FRAME_CLKS + 200) * CLK_PERIOD;

  logic        clk;
  logic        reset;
  logic        spi_sck;
  logic        spi_ss_n;
  logic        spi_mosi;
  logic        spi_miso;
  logic [15:0] lfsr_state;
  int          frames_sent;
  int          frames_checked;
  int          partial_frames;
  int          checker_errors;
  int          tb_errors;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  spi_axil_bridge_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .spi_sck  (spi_sck),
    .spi_ss_n (spi_ss_n),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

  bridge_checker u_checker (
    .spi_sck        (spi_sck),
    .spi_ss_n       (spi_ss_n),
    .spi_mosi       (spi_mosi),
    .spi_miso       (spi_miso),
    .errors         (checker_errors),
    .frames_checked (frames_checked),
    .partial_frames (partial_frames)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1.
  endfunction

  task automatic take_bits(input int n, output logic [DATA_BITS-1:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value      = {value[DATA_BITS-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Shifts nbits of a frame, MSB first; fewer than 32 cuts the frame short.
  // Called on a falling clock edge.
  task automatic send_frame(input spi_frame_t f, input int nbits);
    logic [31:0] bits;
    bits = f;
    spi_ss_n = 1'b0;
    spi_mosi = bits[31];
    repeat (SCK_HALF) @(negedge clk);
    for (int i = 0; i < nbits; i++) begin
      spi_sck = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
      spi_sck = 1'b0;
      if (i < nbits - 1) spi_mosi = bits[30 - i];
      repeat (SCK_HALF) @(negedge clk);
    end
    spi_ss_n = 1'b1;
    if (nbits == 2 * WORD_BITS) frames_sent++;
    repeat (SS_GAP) @(negedge clk);
  endtask

  task automatic run_command(input logic write, input logic [3:0] index,
                             input logic [DATA_BITS-1:0] data);
    spi_frame_t           f;
    logic [DATA_BITS-1:0] junk;
    take_bits(3, junk); // Reserved opcode bits.
    f.opcode.write    = write;
    f.opcode.reserved = junk[2:0];
    f.opcode.index    = index;
    f.data            = data;
    send_frame(f, 2 * WORD_BITS);
  endtask

  initial begin
    logic [DATA_BITS-1:0] data;
    logic [DATA_BITS-1:0] pick;
    spi_frame_t           cut;
    reset      = 1'b1;
    spi_sck    = 1'b0;
    spi_ss_n   = 1'b1;
    spi_mosi   = 1'b0;
    lfsr_state = 16'd24681;
    tb_errors  = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    run_command(1'b0, 4'd0, '0); // ID read, reply comes next frame.
    for (int r = 1; r < NUM_REGS; r++) begin
      take_bits(DATA_BITS, data);
      run_command(1'b1, 4'(r), data);
      run_command(1'b0, 4'(r), '0);
    end

    // Out of range indices, then a write to the ID.
    for (int r = NUM_REGS; r < 16; r++) begin
      take_bits(DATA_BITS, data);
      run_command(1'b1, 4'(r), data);
      run_command(1'b0, 4'(r), '0);
    end
    take_bits(DATA_BITS, data);
    run_command(1'b1, 4'd0, data);
    for (int r = 0; r < NUM_REGS; r++) begin
      run_command(1'b0, 4'(r), '0);
    end

    // Mixed traffic at minimum gap.
    for (int n = 0; n < 8; n++) begin
      take_bits(4, pick);
      take_bits(DATA_BITS, data);
      run_command(pick[3], {1'b0, pick[2:0]}, data);
    end

    // Write to register 2 cut off after 12 bits.
    take_bits(DATA_BITS, data);
    cut.opcode = '{write: 1'b1, reserved: 3'b000, index: 4'd2};
    cut.data   = data;
    send_frame(cut, 12);
    run_command(1'b0, 4'd2, '0);
    run_command(1'b0, 4'd0, '0); // Flushes the last reply.

    repeat (4) @(negedge clk);
    if (partial_frames != 1) begin
      $display("Checker saw %0d cut-short frames, expected 1", partial_frames);
      tb_errors++;
    end
    if (frames_checked != frames_sent) begin
      $display("Checker saw %0d frames but %0d were sent", frames_checked, frames_sent);
      tb_errors++;
    end
    $display("Frames checked: %0d, errors: %0d", frames_checked, checker_errors + tb_errors);
    if (checker_errors + tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
    $display("Frames checked: %0d, errors: %0d", frames_checked, checker_errors + tb_errors + 1);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/spi_bridge_pkg.sv
rtl/spi_word_shifter.sv
rtl/spi_frame_assembler.sv
rtl/spi_axil_master.sv
rtl/axil_reg_bank.sv
rtl/spi_axil_bridge_top.sv
verification/bridge_checker.sv
verification/tb_spi_axil_bridge.sv

/* Makefile */
# Verilator build and run for the SPI to register bridge testbench.
VERILATOR := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := tb_spi_axil_bridge
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
